/* tb/noc_golden.mem */
// One word per flit in hex as T S DD... packed TSDLLPPP
// test id, source node, destination node, expected latency (00 unchecked), payload {src, seq}
// Single flits between every ordered pair
10104001 10204002 10306003 11004404 11206405 11304406
12004807 12106808 12304809 13006C0A 13104C0B 13204C0C
// All to all, two rounds
20100010 20200011 20300012 21000413 21200414 21300415
22000816 22100817 22300818 23000C19 23100C1A 23200C1B
20100020 20200021 20300022 21000423 21200424 21300425
22000826 22100827 22300828 23000C29 23100C2A 23200C2B
// Hot spot on node 0
31000430 32000831 33000C32 31000433 32000834 33000C35 31000436 32000837 33000C38
// Back-pressure on node 3
40300040 41300441 42300842 40300043 41300444 42300845 40300046 41300447 42300848

/* verilog.f */
rtl/noc_pkg.sv
rtl/credit_counter.sv
rtl/input_buffer.sv
rtl/switch_allocator.sv
rtl/noc_router.sv
rtl/noc_mesh.sv
tb/noc_asserts.sv
tb/noc_tb.sv

/* tb/noc_tb.sv */
`timescale 1ns/1ps

module noc_tb import noc_pkg::*; ();

	localparam int NUM_VEC  = 54;
	localparam int NUM_RAND = 24;
	localparam int TIMEOUT  = 40 * (NUM_VEC + NUM_RAND) + 200;

	typedef struct packed {
		logic [PAYLOAD_W-1:0] payload;
		logic [7:0]           lat;
		logic [31:0]          cyc;
	} expect_t;

	logic                  clk;
	logic                  rst_n;
	link_t [NUM_NODES-1:0] local_in;
	link_t [NUM_NODES-1:0] local_out;
	logic [NUM_NODES-1:0]  local_credit_in;
	logic [NUM_NODES-1:0]  local_credit_out;
	logic [NUM_NODES-1:0]  hold;
	logic [31:0]           vec [NUM_VEC];
	logic [31:0]           src_q [NUM_NODES][$];
	expect_t               exp_q [NUM_NODES*NUM_NODES][$];
	int                    inj_credit [NUM_NODES];
	int                    owed [NUM_NODES];
	int                    recv_cnt [NUM_NODES];
	int                    cycle;
	int                    errors;
	string                 cur_test;
	integer                seed;

	noc_mesh DUT (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.local_in_i     (local_in),
		.local_out_o    (local_out),
		.local_credit_i (local_credit_in),
		.local_credit_o (local_credit_out)
	);

	bind noc_router noc_asserts u_asserts (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.link_i        (link_i),
		.out_link_i    (link_o),
		.out_credit_i  (credit_o),
		.cc_count_i    ({g_port[4].u_cc.count, g_port[3].u_cc.count, g_port[2].u_cc.count,
			g_port[1].u_cc.count, g_port[0].u_cc.count}),
		.buf_count_i   ({g_port[4].u_buf.count, g_port[3].u_buf.count, g_port[2].u_buf.count,
			g_port[1].u_buf.count, g_port[0].u_buf.count})
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what, expected,
				actual);
		end
	endtask

	function automatic string test_name(input logic [3:0] tid);
		case (tid)
			4'd1:    return "single";
			4'd2:    return "all_to_all";
			4'd3:    return "hot_spot";
			4'd4:    return "backpressure";
			default: return "random";
		endcase
	endfunction

	// Ejection check, ejection credits and injection, all on the falling edge
	always @(negedge clk) begin
		flit_t       f;
		expect_t     e;
		logic [31:0] w;
		int          pair;
		if (rst_n) begin
			for (int n = 0; n < NUM_NODES; n++) begin
				f = local_out[n].flit;
				if (local_out[n].valid) begin
					// Source id rides in the top payload bits
					pair = int'(f.payload[PAYLOAD_W-1 -: 2]) * NUM_NODES + n;
					recv_cnt[n]++;
					owed[n]++;
					check_value("dest", n, int'(f.dest_y) * MESH_DIM + int'(f.dest_x));
					assert (exp_q[pair].size() > 0) else begin
						errors++;
						$display("Node %0d received flit %0h that was never sent to it", n, f);
					end
					if (exp_q[pair].size() > 0) begin
						e = exp_q[pair].pop_front();
						check_value("payload", e.payload, f.payload);
						if (e.lat != 0) begin
							check_value("latency", e.lat, cycle - int'(e.cyc));
						end
					end
				end
				local_credit_in[n] = !hold[n] && owed[n] > 0;
				if (local_credit_in[n]) begin
					owed[n]--;
				end
				inj_credit[n] += local_credit_out[n];
				local_in[n] = '0;
				if (src_q[n].size() > 0 && inj_credit[n] > 0) begin
					w = src_q[n].pop_front();
					inj_credit[n]--;
					local_in[n].valid        = 1'b1;
					local_in[n].flit.dest_x  = COORD_W'(w[23:20] % MESH_DIM);
					local_in[n].flit.dest_y  = COORD_W'(w[23:20] / MESH_DIM);
					local_in[n].flit.payload = w[11:0];
					e.payload = w[11:0];
					e.lat     = w[19:12];
					e.cyc     = cycle;
					exp_q[int'(w[27:24]) * NUM_NODES + int'(w[23:20])].push_back(e);
				end
			end
		end
	end

	task automatic wait_idle();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			busy = 1'b0;
			for (int n = 0; n < NUM_NODES; n++) begin
				if (src_q[n].size() > 0 || owed[n] > 0 || inj_credit[n] != BUF_DEPTH) begin
					busy = 1'b1;
				end
			end
			for (int p = 0; p < NUM_NODES * NUM_NODES; p++) begin
				if (exp_q[p].size() > 0) begin
					busy = 1'b1;
				end
			end
		end
	endtask

	task automatic run_group(input int first, input int last);
		logic [3:0] tid;
		int         base;
		tid      = vec[first][31:28];
		cur_test = test_name(tid);
		base     = recv_cnt[NUM_NODES-1];
		// Back-pressure holds the ejection credits of the last node
		hold[NUM_NODES-1] = (tid == 4'd4);
		for (int i = first; i <= last; i++) begin
			src_q[vec[i][27:24]].push_back(vec[i]);
		end
		if (tid == 4'd4) begin
			while (recv_cnt[NUM_NODES-1] - base < BUF_DEPTH) begin
				@(posedge clk);
			end
			repeat (8 * BUF_DEPTH) @(posedge clk);
			check_value("stall count", BUF_DEPTH, recv_cnt[NUM_NODES-1] - base);
			hold = '0;
		end
		wait_idle();
	endtask

	task automatic run_random();
		logic [31:0] r;
		logic [3:0]  src;
		logic [3:0]  dst;
		cur_test = test_name(4'd5);
		for (int k = 0; k < NUM_RAND; k++) begin
			r   = $random(seed);
			src = 4'(r[1:0]);
			dst = 4'((int'(r[1:0]) + 1 + int'(r[5:4]) % 3) % NUM_NODES);
			src_q[src].push_back({4'd5, src, dst, 8'd0, r[1:0], r[17:8]});
		end
		wait_idle();
	endtask

	initial begin
		int first;
		errors          = 0;
		cycle           = 0;
		seed            = 32'h0284ff11;
		rst_n           = 1'b0;
		local_in        = '0;
		local_credit_in = '0;
		hold            = '0;
		for (int n = 0; n < NUM_NODES; n++) begin
			inj_credit[n] = BUF_DEPTH;
			owed[n]       = 0;
			recv_cnt[n]   = 0;
		end
		$readmemh("tb/noc_golden.mem", vec);
		assert (!$isunknown(vec[NUM_VEC-1])) else begin
			errors++;
			$display("Golden file tb/noc_golden.mem is missing or too short");
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		first = 0;
		// Single flits go one by one, other tests inject their whole group at once
		for (int i = 0; i < NUM_VEC; i++) begin
			if (i == NUM_VEC - 1 || vec[i][31:28] == 4'd1 ||
					vec[i+1][31:28] != vec[i][31:28]) begin
				run_group(first, i);
				first = i + 1;
			end
		end
		run_random();
		$display("Finished with %0d errors", errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (cycle >= TIMEOUT);
		$display("Timeout after %0d cycles, traffic did not drain", cycle);
		$display("Finished with %0d errors", errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* tb/noc_asserts.sv */
`timescale 1ns/1ps

module noc_asserts import noc_pkg::*; (
	input logic                            clk,
	input logic                            rst_n_i,
	input link_t [NUM_PORTS-1:0]           link_i,
	input link_t [NUM_PORTS-1:0]           out_link_i,
	input logic [NUM_PORTS-1:0]            out_credit_i,
	input logic [NUM_PORTS-1:0][CNT_W-1:0] cc_count_i,
	input logic [NUM_PORTS-1:0][CNT_W-1:0] buf_count_i
);

	// Number of outputs carrying a flit this cycle
	function automatic int valid_count(input link_t [NUM_PORTS-1:0] l);
		int c;
		c = 0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			c += int'(l[p].valid);
		end
		return c;
	endfunction

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
		a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
			cc_count_i[p] <= CNT_W'(BUF_DEPTH))
			else $error("Credit counter of output %0d rose above the buffer depth", p);
		a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
			!(link_i[p].valid && buf_count_i[p] == CNT_W'(BUF_DEPTH)))
			else $error("Input buffer %0d written while full", p);
	end

	// Each departing flit pops its own input and returns exactly one credit
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_count(out_link_i) == $countones(out_credit_i))
		else $error("Flits sent and credits returned differ, one input fed two outputs");

endmodule

/* rtl/noc_mesh.sv */
`timescale 1ns/1ps

module noc_mesh import noc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  link_t [NUM_NODES-1:0] local_in_i,
	output link_t [NUM_NODES-1:0] local_out_o,
	input  logic [NUM_NODES-1:0]  local_credit_i,
	output logic [NUM_NODES-1:0]  local_credit_o
);

	link_t [NUM_PORTS-1:0] rt_in  [NUM_NODES];
	link_t [NUM_PORTS-1:0] rt_out [NUM_NODES];
	logic [NUM_PORTS-1:0]  cr_in  [NUM_NODES];
	logic [NUM_PORTS-1:0]  cr_out [NUM_NODES];

	// Node id is row * MESH_DIM + column, row 0 at the north edge
	for (genvar gy = 0; gy < MESH_DIM; gy++) begin : g_row
		for (genvar gx = 0; gx < MESH_DIM; gx++) begin : g_col
			noc_router #(
				.ROUTER_X (gx),
				.ROUTER_Y (gy)
			) u_router (
				.clk      (clk),
				.rst_n_i  (rst_n_i),
				.link_i   (rt_in[gy * MESH_DIM + gx]),
				.link_o   (rt_out[gy * MESH_DIM + gx]),
				.credit_i (cr_in[gy * MESH_DIM + gx]),
				.credit_o (cr_out[gy * MESH_DIM + gx])
			);
		end
	end

	// Neighbour wiring, off-edge ports stay tied low
	always_comb begin
		for (int n = 0; n < NUM_NODES; n++) begin
			rt_in[n] = '0;
			cr_in[n] = '0;
			rt_in[n][PORT_L]  = local_in_i[n];
			cr_in[n][PORT_L]  = local_credit_i[n];
			local_out_o[n]    = rt_out[n][PORT_L];
			local_credit_o[n] = cr_out[n][PORT_L];
			if (n >= MESH_DIM) begin
				rt_in[n][PORT_N] = rt_out[n - MESH_DIM][PORT_S];
				cr_in[n][PORT_N] = cr_out[n - MESH_DIM][PORT_S];
			end
			if (n < NUM_NODES - MESH_DIM) begin
				rt_in[n][PORT_S] = rt_out[n + MESH_DIM][PORT_N];
				cr_in[n][PORT_S] = cr_out[n + MESH_DIM][PORT_N];
			end
			if (n % MESH_DIM != 0) begin
				rt_in[n][PORT_W] = rt_out[n - 1][PORT_E];
				cr_in[n][PORT_W] = cr_out[n - 1][PORT_E];
			end
			if (n % MESH_DIM != MESH_DIM - 1) begin
				rt_in[n][PORT_E] = rt_out[n + 1][PORT_W];
				cr_in[n][PORT_E] = cr_out[n + 1][PORT_W];
			end
		end
	end

endmodule

/* rtl/noc_router.sv */
`timescale 1ns/1ps

module noc_router import noc_pkg::*; #(
	parameter int ROUTER_X = 0,
	parameter int ROUTER_Y = 0
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  link_t [NUM_PORTS-1:0] link_i,
	output link_t [NUM_PORTS-1:0] link_o,
	input  logic [NUM_PORTS-1:0]  credit_i,
	output logic [NUM_PORTS-1:0]  credit_o
);

	flit_t [NUM_PORTS-1:0] head;
	logic [NUM_PORTS-1:0]  head_valid;
	port_e [NUM_PORTS-1:0] route;
	logic [NUM_PORTS-1:0]  pop;
	logic [NUM_PORTS-1:0]  out_ready;
	port_e [NUM_PORTS-1:0] grant;
	logic [NUM_PORTS-1:0]  grant_valid;
	logic [NUM_PORTS-1:0]  out_valid_q;
	flit_t [NUM_PORTS-1:0] out_flit_q;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		input_buffer #(
			.ROUTER_X (ROUTER_X),
			.ROUTER_Y (ROUTER_Y)
		) u_buf (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.link_i       (link_i[p]),
			.pop_i        (pop[p]),
			.head_o       (head[p]),
			.head_valid_o (head_valid[p]),
			.route_o      (route[p]),
			.credit_o     (credit_o[p])
		);

		// Tracks free slots in the buffer behind output p
		credit_counter u_cc (
			.clk      (clk),
			.rst_n_i  (rst_n_i),
			.send_i   (grant_valid[p]),
			.credit_i (credit_i[p]),
			.ready_o  (out_ready[p])
		);
	end

	switch_allocator u_alloc (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.req_valid_i   (head_valid),
		.req_route_i   (route),
		.out_ready_i   (out_ready),
		.grant_o       (grant),
		.grant_valid_o (grant_valid),
		.pop_o         (pop)
	);

	// Crossbar, granted head flit registered onto each output
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_valid_q <= '0;
		end else begin
			out_valid_q <= grant_valid;
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (grant_valid[o]) begin
				out_flit_q[o] <= head[grant[o]];
			end
		end
	end

	always_comb begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			link_o[o].valid = out_valid_q[o];
			link_o[o].flit  = out_flit_q[o];
		end
	end

endmodule

/* rtl/switch_allocator.sv */
`timescale 1ns/1ps

module switch_allocator import noc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [NUM_PORTS-1:0]  req_valid_i,
	input  port_e [NUM_PORTS-1:0] req_route_i,
	input  logic [NUM_PORTS-1:0]  out_ready_i,
	output port_e [NUM_PORTS-1:0] grant_o,
	output logic [NUM_PORTS-1:0]  grant_valid_o,
	output logic [NUM_PORTS-1:0]  pop_o
);

	// Highest-priority input for each output
	port_e [NUM_PORTS-1:0] rr_ptr;

	function automatic port_e next_port(input port_e p);
		return (p == PORT_L) ? PORT_N : port_e'(p + 1'b1);
	endfunction

	// Scan the inputs starting at the pointer, first match wins
	always_comb begin
		int idx;
		for (int o = 0; o < NUM_PORTS; o++) begin
			grant_valid_o[o] = 1'b0;
			grant_o[o]       = PORT_N;
			for (int k = 0; k < NUM_PORTS; k++) begin
				idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
				if (!grant_valid_o[o] && out_ready_i[o] && req_valid_i[idx] &&
						req_route_i[idx] == port_e'(o)) begin
					grant_valid_o[o] = 1'b1;
					grant_o[o]       = port_e'(idx);
				end
			end
		end
	end

	// Each input requests one output only, so at most one grant per input
	always_comb begin
		pop_o = '0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (grant_valid_o[o]) begin
				pop_o[grant_o[o]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				rr_ptr[o] <= PORT_N;
			end
		end else begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (grant_valid_o[o]) begin
					rr_ptr[o] <= next_port(grant_o[o]);
				end
			end
		end
	end

endmodule

/* rtl/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer import noc_pkg::*; #(
	parameter int ROUTER_X = 0,
	parameter int ROUTER_Y = 0
) (
	input  logic  clk,
	input  logic  rst_n_i,
	input  link_t link_i,
	input  logic  pop_i,
	output flit_t head_o,
	output logic  head_valid_o,
	output port_e route_o,
	output logic  credit_o
);

	flit_t            mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	assign head_valid_o = (count != '0);
	assign do_pop       = pop_i && head_valid_o;
	assign head_o       = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (link_i.valid) begin
			mem[wr_ptr] <= link_i.flit;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (link_i.valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({link_i.valid, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit back upstream per departing flit
			credit_o <= do_pop;
		end
	end

	// YX order, resolve the row before the column
	always_comb begin
		if (head_o.dest_y < COORD_W'(ROUTER_Y)) begin
			route_o = PORT_N;
		end else if (head_o.dest_y > COORD_W'(ROUTER_Y)) begin
			route_o = PORT_S;
		end else if (head_o.dest_x < COORD_W'(ROUTER_X)) begin
			route_o = PORT_W;
		end else if (head_o.dest_x > COORD_W'(ROUTER_X)) begin
			route_o = PORT_E;
		end else begin
			route_o = PORT_L;
		end
	end

endmodule

/* rtl/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter import noc_pkg::*; (
	input  logic clk,
	input  logic rst_n_i,
	input  logic send_i,
	input  logic credit_i,
	output logic ready_o
);

	// Free slots left in the downstream input buffer
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count <= CNT_W'(BUF_DEPTH);
		end else begin
			case ({send_i, credit_i})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign ready_o = (count != '0);

endmodule

/* rtl/noc_pkg.sv */
package noc_pkg;

	// Mesh geometry
	localparam int MESH_DIM  = 2;
	localparam int NUM_NODES = MESH_DIM * MESH_DIM;
	localparam int NUM_PORTS = 5;

	// Flit layout, coordinates as in the YX address format
	localparam int COORD_W   = 2;
	localparam int PAYLOAD_W = 12;
	localparam int FLIT_W    = 2 * COORD_W + PAYLOAD_W;

	// Buffering and credits
	localparam int BUF_DEPTH = 4;
	localparam int PTR_W     = $clog2(BUF_DEPTH);
	localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_e;

	typedef struct packed {
		logic [COORD_W-1:0]   dest_x;
		logic [COORD_W-1:0]   dest_y;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// One direction of a link, valid strobe plus flit
	typedef struct packed {
		logic  valid;
		flit_t flit;
	} link_t;

endpackage
